//--- Bender.yml
package:
  name: fp16_add

sources:
  # Design, package first
  - src/fp16AddPkg.sv
  - src/operandUnpack.sv
  - src/alignShiftStage.sv
  - src/mantissaAdder.sv
  - src/normalizeRound.sv
  - src/fp16AddTop.sv
  # Testbench, bound assertions before the top
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/fp16Add_asserts.sv
      - testbench/fp16AddTb.sv

//--- compile.f
+incdir+testbench
src/fp16AddPkg.sv
src/operandUnpack.sv
src/alignShiftStage.sv
src/mantissaAdder.sv
src/normalizeRound.sv
src/fp16AddTop.sv
testbench/fp16Add_asserts.sv
testbench/fp16AddTb.sv

//--- src/alignShiftStage.sv
`timescale 1ns/1ps

module alignShiftStage #(
	parameter int StageShift = 8  // Power of two, one bit of the shift field
) (
	input  logic                   aclk,
	input  logic                   rst,
	input  logic                   aclken,
	input  logic                   inValid,
	input  fp16AddPkg::alignBundle inBundle,
	output logic                   outValid,
	output fp16AddPkg::alignBundle outBundle
);

	localparam fp16AddPkg::shiftAmt StepBit  = fp16AddPkg::shiftAmt'(StageShift);
	localparam fp16AddPkg::wideSig  LostMask = fp16AddPkg::wideSig'((1 << StageShift) - 1);

	fp16AddPkg::alignBundle nextBundle;
	logic                   doShift;
	logic                   lostBits;

	assign doShift  = (inBundle.shift & StepBit) != '0;
	assign lostBits = (inBundle.sigSmall & LostMask) != '0;  // Includes old sticky

	always_comb begin
		nextBundle = inBundle;
		if (doShift) begin
			// Jam everything shifted out into bit 0
			nextBundle.sigSmall = (inBundle.sigSmall >> StageShift)
				| fp16AddPkg::wideSig'(lostBits);
			nextBundle.shift = inBundle.shift & ~StepBit;  // This step done
		end
	end

	always_ff @(posedge aclk) begin
		if (rst) begin
			outValid <= 1'b0;
		end else if (aclken) begin
			outValid <= inValid;
		end
	end

	always_ff @(posedge aclk) begin
		if (aclken) begin
			outBundle <= nextBundle;
		end
	end

endmodule

//--- src/fp16AddPkg.sv
package fp16AddPkg;

	// Binary16 field widths
	typedef logic [15:0] fp16Word;    // Sign, exponent, fraction
	typedef logic [4:0]  expField;    // Biased exponent
	typedef logic [9:0]  fracField;   // Stored fraction
	typedef logic [10:0] sigField;    // Fraction with hidden one

	// Datapath widths
	typedef logic [13:0] wideSig;     // Significand plus guard, round, sticky
	typedef logic [14:0] sumSig;      // Adder output with carry on top
	typedef logic [3:0]  shiftAmt;    // Alignment distance, saturates at 15

	// Result class carried down the pipe
	typedef logic [1:0] specialCode;

	localparam specialCode specNone = 2'd0;  // Ordinary finite arithmetic
	localparam specialCode specInf  = 2'd1;  // Signed infinity out
	localparam specialCode specNaN  = 2'd2;  // Quiet NaN out

	// All-ones exponent marks inf and NaN
	localparam expField expMax = 5'h1F;

	// Canonical quiet NaN
	localparam fp16Word qNaN = 16'h7E00;

	// Unpack and align stages
	// Smaller significand sits at the top of sigSmall before any shift
	typedef struct packed {
		logic       sign;      // Sign of larger operand
		expField    exp;       // Common exponent
		sigField    sigLarge;  // Larger significand
		wideSig     sigSmall;  // Smaller significand, shifted in place
		shiftAmt    shift;     // Shift still to do
		logic       effSub;    // Signs differ
		specialCode special;
	} alignBundle;

	// Adder to normalize stage
	typedef struct packed {
		logic       sign;      // Already fixed up for exact cancellation
		expField    exp;       // Common exponent, not yet adjusted
		sumSig      sum;
		specialCode special;
	} sumBundle;

endpackage

//--- src/fp16AddTop.sv
`timescale 1ns/1ps

module fp16AddTop (
	input  logic                aclk,
	input  logic                rst,
	input  logic                aclken,   // Low freezes every stage
	input  logic                aValid,
	input  fp16AddPkg::fp16Word aData,
	input  logic                bValid,
	input  fp16AddPkg::fp16Word bData,
	output logic                resultValid,
	output fp16AddPkg::fp16Word resultData
);

	localparam int NumShift = 4;  // Steps of 8, 4, 2, 1

	logic                   issueValid;
	fp16AddPkg::alignBundle alignChain [0:NumShift];
	logic                   alignValid [0:NumShift];
	fp16AddPkg::sumBundle   sumStage;
	logic                   sumValid;

	// Both operands needed to issue
	assign issueValid = aValid & bValid;

	operandUnpack u_unpack (
		.aclk     (aclk),
		.rst      (rst),
		.aclken   (aclken),
		.inValid  (issueValid),
		.aData    (aData),
		.bData    (bData),
		.outValid (alignValid[0]),
		.align    (alignChain[0])
	);

	// Largest step first
	for (genvar i = 0; i < NumShift; i++) begin : g_shift
		alignShiftStage #(
			.StageShift (8 >> i)
		) u_shift (
			.aclk      (aclk),
			.rst       (rst),
			.aclken    (aclken),
			.inValid   (alignValid[i]),
			.inBundle  (alignChain[i]),
			.outValid  (alignValid[i+1]),
			.outBundle (alignChain[i+1])
		);
	end

	mantissaAdder u_adder (
		.aclk     (aclk),
		.rst      (rst),
		.aclken   (aclken),
		.inValid  (alignValid[NumShift]),
		.align    (alignChain[NumShift]),
		.outValid (sumValid),
		.sum      (sumStage)
	);

	normalizeRound u_round (
		.aclk        (aclk),
		.rst         (rst),
		.aclken      (aclken),
		.inValid     (sumValid),
		.sum         (sumStage),
		.resultValid (resultValid),
		.resultData  (resultData)
	);

endmodule

//--- src/mantissaAdder.sv
`timescale 1ns/1ps

module mantissaAdder (
	input  logic                   aclk,
	input  logic                   rst,
	input  logic                   aclken,
	input  logic                   inValid,
	input  fp16AddPkg::alignBundle align,
	output logic                   outValid,
	output fp16AddPkg::sumBundle   sum
);

	fp16AddPkg::wideSig   largeExt;
	fp16AddPkg::sumSig    result;
	fp16AddPkg::sumBundle nextSum;
	logic                 cancelled;

	// Larger significand gets empty GRS positions
	assign largeExt = {align.sigLarge, 3'b000};

	// Larger magnitude first, so the difference stays non-negative
	assign result = align.effSub
		? ({1'b0, largeExt} - {1'b0, align.sigSmall})
		: ({1'b0, largeExt} + {1'b0, align.sigSmall});

	// Exact zero from opposite signs is +0
	assign cancelled = align.effSub && (result == '0);

	always_comb begin
		nextSum.sign    = cancelled ? 1'b0 : align.sign;
		nextSum.exp     = align.exp;
		nextSum.sum     = result;
		nextSum.special = align.special;
	end

	always_ff @(posedge aclk) begin
		if (rst) begin
			outValid <= 1'b0;
		end else if (aclken) begin
			outValid <= inValid;
		end
	end

	always_ff @(posedge aclk) begin
		if (aclken) begin
			sum <= nextSum;
		end
	end

endmodule

//--- src/normalizeRound.sv
`timescale 1ns/1ps

module normalizeRound (
	input  logic                 aclk,
	input  logic                 rst,
	input  logic                 aclken,
	input  logic                 inValid,
	input  fp16AddPkg::sumBundle sum,
	output logic                 resultValid,
	output fp16AddPkg::fp16Word  resultData
);

	fp16AddPkg::wideSig   normSig;     // Leading one at bit 13
	fp16AddPkg::sigField  sigTrunc;
	fp16AddPkg::fracField fracOut;
	fp16AddPkg::fp16Word  nextWord;
	logic [3:0]           lead;        // Leading zeros in sum[13:0]
	logic [6:0]           expNorm;     // Bit 6 set means negative
	logic [6:0]           expRound;
	logic [11:0]          sigRound;    // Top bit is rounding carry out
	logic                 carry;
	logic                 guardBit, roundBit, stickyBit, roundUp;
	logic                 isZero, flush, overflow;

	assign carry = sum.sum[14];

	// Priority encoder, highest set bit wins
	always_comb begin
		lead = 4'd14;
		for (int i = 0; i < 14; i++) begin
			if (sum.sum[i]) begin
				lead = 4'(13 - i);
			end
		end
	end

	always_comb begin
		if (carry) begin
			// Drop one bit into sticky
			normSig = {sum.sum[14:2], sum.sum[1] | sum.sum[0]};
			expNorm = {2'b00, sum.exp} + 7'd1;
		end else begin
			normSig = sum.sum[13:0] << lead;  // Only exact results need big shifts
			expNorm = {2'b00, sum.exp} - {3'b000, lead};
		end
	end

	assign sigTrunc  = normSig[13:3];
	assign guardBit  = normSig[2];
	assign roundBit  = normSig[1];
	assign stickyBit = normSig[0];

	// Nearest, ties to even
	assign roundUp  = guardBit & (roundBit | stickyBit | sigTrunc[0]);
	assign sigRound = {1'b0, sigTrunc} + {11'd0, roundUp};
	assign fracOut  = sigRound[11] ? sigRound[10:1] : sigRound[9:0];
	assign expRound = expNorm + {6'd0, sigRound[11]};  // Renormalize on carry out

	assign isZero   = (sum.sum == '0);
	assign flush    = expNorm[6] || (expNorm == 7'd0);  // Below 2^-14 before rounding
	assign overflow = (expRound >= 7'd31);

	always_comb begin
		if (sum.special == fp16AddPkg::specNaN) begin
			nextWord = fp16AddPkg::qNaN;
		end else if (sum.special == fp16AddPkg::specInf) begin
			nextWord = {sum.sign, fp16AddPkg::expMax, 10'd0};
		end else if (isZero || flush) begin
			nextWord = {sum.sign, 15'd0};  // Sign already resolved upstream
		end else if (overflow) begin
			nextWord = {sum.sign, fp16AddPkg::expMax, 10'd0};
		end else begin
			nextWord = {sum.sign, expRound[4:0], fracOut};
		end
	end

	// Output register, holds while stalled
	always_ff @(posedge aclk) begin
		if (rst) begin
			resultValid <= 1'b0;
		end else if (aclken) begin
			resultValid <= inValid;
		end
	end

	always_ff @(posedge aclk) begin
		if (aclken) begin
			resultData <= nextWord;
		end
	end

endmodule

//--- src/operandUnpack.sv
`timescale 1ns/1ps

module operandUnpack (
	input  logic                   aclk,
	input  logic                   rst,
	input  logic                   aclken,
	input  logic                   inValid,
	input  fp16AddPkg::fp16Word    aData,
	input  fp16AddPkg::fp16Word    bData,
	output logic                   outValid,
	output fp16AddPkg::alignBundle align
);

	fp16AddPkg::expField    aExp, bExp;
	fp16AddPkg::fracField   aFrac, bFrac;
	fp16AddPkg::sigField    aSig, bSig;
	fp16AddPkg::expField    expLarge, expSmall;
	fp16AddPkg::expField    expDiff;
	fp16AddPkg::alignBundle nextAlign;
	logic                   aNaN, bNaN, aInf, bInf, aZero, bZero;
	logic [14:0]            aMag, bMag;   // Magnitude keys for ordering
	logic                   bLarger;

	assign aExp  = aData[14:10];
	assign bExp  = bData[14:10];
	assign aFrac = aData[9:0];
	assign bFrac = bData[9:0];

	// Classify
	assign aNaN  = (aExp == fp16AddPkg::expMax) && (aFrac != '0);
	assign bNaN  = (bExp == fp16AddPkg::expMax) && (bFrac != '0);
	assign aInf  = (aExp == fp16AddPkg::expMax) && (aFrac == '0);
	assign bInf  = (bExp == fp16AddPkg::expMax) && (bFrac == '0);
	assign aZero = (aExp == '0);  // Subnormals flush to zero here
	assign bZero = (bExp == '0);

	// Flushed operands order as zero
	assign aMag = aZero ? 15'd0 : aData[14:0];
	assign bMag = bZero ? 15'd0 : bData[14:0];
	assign bLarger = (bMag > aMag);  // Ties keep A as larger

	// Hidden one only for normals
	assign aSig = aZero ? 11'd0 : {1'b1, aFrac};
	assign bSig = bZero ? 11'd0 : {1'b1, bFrac};

	assign expLarge = bLarger ? bExp : aExp;
	assign expSmall = bLarger ? aExp : bExp;
	assign expDiff  = expLarge - expSmall;  // Never negative after ordering

	always_comb begin
		nextAlign.sign     = bLarger ? bData[15] : aData[15];
		nextAlign.exp      = expLarge;
		nextAlign.sigLarge = bLarger ? bSig : aSig;
		nextAlign.sigSmall = {(bLarger ? aSig : bSig), 3'b000};  // GRS start empty
		nextAlign.shift    = (expDiff > 5'd15) ? 4'd15 : expDiff[3:0];  // 15 clears all
		nextAlign.effSub   = aData[15] ^ bData[15];

		// NaN wins, then inf minus inf, then any inf
		if (aNaN || bNaN) begin
			nextAlign.special = fp16AddPkg::specNaN;
		end else if (aInf && bInf && (aData[15] != bData[15])) begin
			nextAlign.special = fp16AddPkg::specNaN;
		end else if (aInf || bInf) begin
			nextAlign.special = fp16AddPkg::specInf;  // Inf always orders larger
		end else begin
			nextAlign.special = fp16AddPkg::specNone;
		end
	end

	// Valid bit
	always_ff @(posedge aclk) begin
		if (rst) begin
			outValid <= 1'b0;
		end else if (aclken) begin
			outValid <= inValid;
		end
	end

	always_ff @(posedge aclk) begin
		if (aclken) begin
			align <= nextAlign;
		end
	end

endmodule

//--- testbench/fp16AddRef.svh
`ifndef FP16_ADD_REF_SVH
`define FP16_ADD_REF_SVH

// Exact operand value in units of 2^-24
function automatic longint scaledValue(input fp16AddPkg::fp16Word w);
	longint mag;
	if (w[14:10] == 5'd0) begin
		mag = 0;  // Subnormal or zero
	end else begin
		mag = longint'({1'b1, w[9:0]}) << (w[14:10] - 5'd1);
	end
	return w[15] ? -mag : mag;
endfunction

// Expected sum, exact then rounded once to 11 significant bits
function automatic fp16AddPkg::fp16Word refAdd(input fp16AddPkg::fp16Word a,
		input fp16AddPkg::fp16Word b);
	longint total, mag, mant, rem, half;
	int     lead, shift, biased;
	logic   sign, aNaN, bNaN, aInf, bInf;
	aNaN = (a[14:10] == 5'h1F) && (a[9:0] != 10'd0);
	bNaN = (b[14:10] == 5'h1F) && (b[9:0] != 10'd0);
	aInf = (a[14:10] == 5'h1F) && (a[9:0] == 10'd0);
	bInf = (b[14:10] == 5'h1F) && (b[9:0] == 10'd0);
	if (aNaN || bNaN || (aInf && bInf && (a[15] != b[15]))) begin
		return 16'h7E00;
	end
	if (aInf) return a;
	if (bInf) return b;
	total = scaledValue(a) + scaledValue(b);
	if (total == 0) begin
		return {a[15] & b[15], 15'd0};  // Only two negative zeros stay negative
	end
	sign = (total < 0);
	mag  = sign ? -total : total;
	lead = 0;
	for (int i = 0; i < 63; i++) begin
		if (mag[i]) lead = i;
	end
	if (lead < 10) return {sign, 15'd0};  // Below 2^-14
	shift = lead - 10;
	mant  = mag >> shift;
	if (shift > 0) begin
		rem  = mag & ((longint'(1) << shift) - 1);
		half = longint'(1) << (shift - 1);
		if ((rem > half) || ((rem == half) && mant[0])) mant = mant + 1;
	end
	if (mant == 2048) begin
		mant = 1024;  // Rounded up to next binade
		lead++;
	end
	biased = lead - 9;
	if (biased >= 31) return {sign, 5'h1F, 10'd0};
	return {sign, 5'(biased), mant[9:0]};
endfunction

function automatic logic [31:0] xorshift32(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

`endif

//--- testbench/fp16AddTb.sv
`timescale 1ns/1ps

module fp16AddTb;

	localparam int ClockPeriod = 40;
	localparam int Latency     = 7;     // Enabled edges from accept to pop
	localparam int StallLimit  = 64;    // Tries per issue under random aclken
	localparam int DrainLimit  = 400;
	localparam int RandomPairs = 2000;
	localparam int StallPairs  = 400;

	logic                aclk, rst, aclken;
	logic                aValid, bValid, resultValid;
	fp16AddPkg::fp16Word aData, bData, resultData;

	logic [31:0]         rngState;
	logic                stallMode;     // Random aclken drops and valid gaps
	int                  enabledEdges;
	int                  checkCount, errorCount, timeoutCount;
	fp16AddPkg::fp16Word expQ[$];       // Expected words in issue order
	string               nameQ[$];
	int                  edgeQ[$];      // Enabled edge of each accept

	`include "fp16AddRef.svh"

	fp16AddTop u_dut (
		.aclk        (aclk),
		.rst         (rst),
		.aclken      (aclken),
		.aValid      (aValid),
		.aData       (aData),
		.bValid      (bValid),
		.bData       (bData),
		.resultValid (resultValid),
		.resultData  (resultData)
	);

	initial begin
		aclk = 1'b0;
		forever #(ClockPeriod / 2) aclk = ~aclk;
	end

	function automatic logic [31:0] nextRandom();
		rngState = xorshift32(rngState);
		return rngState;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checkCount++;
		if (expected !== actual) begin
			errorCount++;
			$display("mismatch %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// Values land on the next rising edge
	task automatic driveCycle(input logic valA, input logic valB, input fp16AddPkg::fp16Word a,
			input fp16AddPkg::fp16Word b, input logic en);
		@(posedge aclk);
		aclken <= en;
		aValid <= valA;
		bValid <= valB;
		aData  <= a;
		bData  <= b;
	endtask

	task automatic issueOp(input string name, input fp16AddPkg::fp16Word a,
			input fp16AddPkg::fp16Word b);
		int          tries;
		int          gapLen;
		int          gapSel;
		logic        en;
		logic        accepted;
		logic [31:0] junk;
		if (stallMode && (nextRandom() % 4 == 0)) begin
			gapLen = 1 + nextRandom() % 3;
			for (int g = 0; g < gapLen; g++) begin
				gapSel = nextRandom() % 3;  // Neither, only A, only B
				junk   = nextRandom();
				driveCycle(gapSel == 1, gapSel == 2, junk[15:0], junk[31:16], junk[7]);
			end
		end
		accepted = 1'b0;
		tries    = 0;
		while (!accepted && (tries < StallLimit)) begin
			en = !stallMode || (nextRandom() % 4 != 0);
			driveCycle(1'b1, 1'b1, a, b, en);
			accepted = en;
			tries++;
		end
		if (accepted) begin
			expQ.push_back(refAdd(a, b));
			nameQ.push_back(name);
		end else begin
			timeoutCount++;
			$display("timeout: operation %s was never accepted", name);
		end
	endtask

	task automatic waitDrain(input string name);
		int cycles;
		cycles = 0;
		while ((expQ.size() != 0) && (cycles < DrainLimit)) begin
			driveCycle(1'b0, 1'b0, 16'h0000, 16'h0000, 1'b1);
			cycles++;
		end
		if (expQ.size() != 0) begin
			timeoutCount++;
			$display("timeout: %0d results of %s never came out", expQ.size(), name);
			expQ.delete();
			nameQ.delete();
			edgeQ.delete();
		end
	endtask

	// Normal operands with exponent gap 0 to 29
	task automatic makeRandomPair(output fp16AddPkg::fp16Word a, output fp16AddPkg::fp16Word b);
		int                  gap, expHi, expLo;
		logic [31:0]         r;
		fp16AddPkg::fp16Word t;
		gap   = nextRandom() % 30;
		expHi = gap + 1 + nextRandom() % (30 - gap);
		expLo = expHi - gap;
		r = nextRandom();
		a = {r[31], 5'(expHi), r[9:0]};
		r = nextRandom();
		b = {r[31], 5'(expLo), r[9:0]};
		if (r[20]) begin
			t = a;  // Smaller operand first half the time
			a = b;
			b = t;
		end
	endtask

	// Scoreboard, one pop per enabled edge with a result
	always @(posedge aclk) begin : compareResults
		string name;
		if (!rst && aclken) begin
			enabledEdges++;
			if (aValid && bValid) edgeQ.push_back(enabledEdges);
			if (resultValid === 1'b1) begin
				if ((expQ.size() == 0) || (edgeQ.size() == 0)) begin
					errorCount++;
					$display("unexpected result %h with no operation pending", resultData);
				end else begin
					name = nameQ.pop_front();
					checkValue(name, expQ.pop_front(), resultData);
					checkValue({name, " latency"}, Latency, enabledEdges - edgeQ.pop_front());
				end
			end
		end
	end

	initial begin : mainFlow
		fp16AddPkg::fp16Word opA, opB;
		rngState     = 32'ha633;
		rst          = 1'b1;
		aclken       = 1'b1;
		aValid       = 1'b0;
		bValid       = 1'b0;
		aData        = 16'h0000;
		bData        = 16'h0000;
		stallMode    = 1'b0;
		enabledEdges = 0;
		checkCount   = 0;
		errorCount   = 0;
		timeoutCount = 0;
		repeat (2) @(posedge aclk);
		rst <= 1'b0;

		issueOp("1.0+1.0", 16'h3C00, 16'h3C00);
		issueOp("1.5+0.25", 16'h3E00, 16'h3400);
		issueOp("65504-65504", 16'h7BFF, 16'hFBFF);
		issueOp("2.0-0.5", 16'h4000, 16'hB800);
		waitDrain("directed");

		issueOp("x-x", 16'h5555, 16'hD555);
		issueOp("-0+-0", 16'h8000, 16'h8000);
		issueOp("+0+-0", 16'h0000, 16'h8000);
		issueOp("tiny positive flush", 16'h0401, 16'h8400);
		issueOp("tiny negative flush", 16'h8401, 16'h0400);
		issueOp("subnormal input", 16'h0200, 16'h3C00);
		waitDrain("zero");

		issueOp("nan a", 16'h7E01, 16'h3C00);
		issueOp("nan b", 16'h3C00, 16'hFC01);
		issueOp("inf-inf", 16'h7C00, 16'hFC00);
		issueOp("inf+finite", 16'h7C00, 16'hC000);
		issueOp("-inf+finite", 16'h3C00, 16'hFC00);
		issueOp("-inf+-inf", 16'hFC00, 16'hFC00);
		issueOp("overflow", 16'h7BFF, 16'h7BFF);
		waitDrain("special");

		for (int n = 0; n < RandomPairs; n++) begin
			makeRandomPair(opA, opB);
			issueOp("random", opA, opB);
		end
		waitDrain("random");

		stallMode = 1'b1;
		for (int n = 0; n < StallPairs; n++) begin
			makeRandomPair(opA, opB);
			issueOp("stall", opA, opB);
		end
		issueOp("stall inf-inf", 16'h7C00, 16'hFC00);
		issueOp("stall x-x", 16'hC123, 16'h4123);
		waitDrain("stall");

		$display("checks %0d, mismatches %0d, timeouts %0d", checkCount, errorCount, timeoutCount);
		if ((errorCount == 0) && (timeoutCount == 0)) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

//--- testbench/fp16Add_asserts.sv
`timescale 1ns/1ps

module fp16AddAsserts (
	input logic                aclk,
	input logic                rst,
	input logic                aclken,
	input logic                aValid,
	input logic                bValid,
	input logic                resultValid,
	input fp16AddPkg::fp16Word resultData
);

	logic [6:0] issuePipe;  // Accepted issues in flight, one bit per stage

	always_ff @(posedge aclk) begin
		if (rst) begin
			issuePipe <= '0;
		end else if (aclken) begin
			issuePipe <= {issuePipe[5:0], aValid & bValid};
		end
	end

	resetClears: assert property (@(posedge aclk) rst |=> !resultValid)
		else $error("resultValid high on the cycle after reset");

	validHolds: assert property (@(posedge aclk) disable iff (rst)
		!aclken |=> $stable(resultValid))
		else $error("resultValid changed while aclken was low");

	dataHolds: assert property (@(posedge aclk) disable iff (rst)
		!aclken |=> $stable(resultData))
		else $error("resultData changed while aclken was low");

	// Valid out exactly 7 enabled edges after accept
	latencyExact: assert property (@(posedge aclk) disable iff (rst)
		resultValid == issuePipe[6])
		else $error("resultValid does not match an issue 7 enabled edges back");

endmodule

bind fp16AddTop fp16AddAsserts u_asserts (
	.aclk        (aclk),
	.rst         (rst),
	.aclken      (aclken),
	.aValid      (aValid),
	.bValid      (bValid),
	.resultValid (resultValid),
	.resultData  (resultData)
);
